// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
LINTFLAGS = --lint-only --timing --assert
TOP       = tb_exec_stage
FILELIST  = project.f
PASS_MSG  = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulation passes only if the pass message shows up in its output
run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== include/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// ****************************************
// Datapath widths
// ****************************************
`define XLEN    32
`define REG_AW  5
`define EXC_W   8

// ****************************************
// Exception vector bit positions
// ****************************************
// Only the two low bits are raised in this stage
`define EXC_OVF 0
`define EXC_RI  1

`endif

// ==== project.f ====
+incdir+include
src/cpu_pkg.sv
src/master_alu.sv
src/slave_alu.sv
src/pipe_ctrl.sv
src/ex_mem.sv
src/exec_stage.sv
test/tb_exec_stage.sv

// ==== src/cpu_pkg.sv ====
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_SRL,
        OP_LUI,
        OP_MULT,
        OP_MULTU
    } alu_op_t;

    // ****************************************
    // Issue packets from decode
    // ****************************************
    typedef struct packed {
        alu_op_t             op;
        logic [`XLEN-1:0]    src_a;
        logic [`XLEN-1:0]    src_b;
        logic [`XLEN-1:0]    rt_value;  // Store data
        logic [`XLEN-1:0]    pc;
        logic [`XLEN-1:0]    inst;
        logic [`REG_AW-1:0]  reg_waddr;
        logic [`REG_AW-1:0]  rd;
        logic                reg_wen;
        logic                mem_en;
        logic                memtoreg;
        logic                cp0write;
        logic                is_in_delayslot;
        logic [`EXC_W-1:0]   except;
    } ex_master_t;

    typedef struct packed {
        alu_op_t             op;
        logic [`XLEN-1:0]    src_a;
        logic [`XLEN-1:0]    src_b;
        logic [`XLEN-1:0]    pc;
        logic [`XLEN-1:0]    inst;
        logic [`REG_AW-1:0]  reg_waddr;
        logic                reg_wen;
        logic                memtoreg;
        logic                cp0write;
        logic                is_in_delayslot;
        logic [`EXC_W-1:0]   except;
    } ex_slave_t;

    // ****************************************
    // Memory-stage packets
    // ****************************************
    typedef struct packed {
        alu_op_t             op;
        logic [`XLEN-1:0]    rt_value;
        logic [`XLEN-1:0]    pc;
        logic [`XLEN-1:0]    inst;
        logic [`REG_AW-1:0]  reg_waddr;
        logic [`REG_AW-1:0]  rd;
        logic                reg_wen;
        logic                mem_en;
        logic                memtoreg;
        logic                cp0write;
        logic                is_in_delayslot;
        logic [`EXC_W-1:0]   except;
        logic [`XLEN-1:0]    alu_res;
        logic [2*`XLEN-1:0]  alu_out64;  // HI in the upper word
        logic                hilowrite;
    } mem_master_t;

    typedef struct packed {
        alu_op_t             op;
        logic [`XLEN-1:0]    pc;
        logic [`XLEN-1:0]    inst;
        logic [`REG_AW-1:0]  reg_waddr;
        logic                reg_wen;
        logic                memtoreg;
        logic                cp0write;
        logic                is_in_delayslot;
        logic [`EXC_W-1:0]   except;
        logic [`XLEN-1:0]    alu_res;
    } mem_slave_t;

    // Single-word result shared by both lanes, multiplies give zero here
    function automatic logic [`XLEN-1:0] alu_word(
        alu_op_t          op,
        logic [`XLEN-1:0] a,
        logic [`XLEN-1:0] b
    );
        logic [`XLEN-1:0] r;
        case (op)
            OP_ADD, OP_ADDU: r = a + b;
            OP_SUB:          r = a - b;
            OP_AND:          r = a & b;
            OP_OR:           r = a | b;
            OP_XOR:          r = a ^ b;
            OP_SLT:          r = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            OP_SLL:          r = a << b[$clog2(`XLEN)-1:0];
            OP_SRL:          r = a >> b[$clog2(`XLEN)-1:0];
            OP_LUI:          r = b << 16;
            default:         r = '0;
        endcase
        return r;
    endfunction

    // Signed overflow for ADD and SUB, judged from the sign bits
    function automatic logic alu_ovf(
        alu_op_t          op,
        logic [`XLEN-1:0] a,
        logic [`XLEN-1:0] b,
        logic [`XLEN-1:0] r
    );
        logic ovf;
        case (op)
            OP_ADD:  ovf = (a[`XLEN-1] == b[`XLEN-1]) && (r[`XLEN-1] != a[`XLEN-1]);
            OP_SUB:  ovf = (a[`XLEN-1] != b[`XLEN-1]) && (r[`XLEN-1] != a[`XLEN-1]);
            default: ovf = 1'b0;
        endcase
        return ovf;
    endfunction

endpackage

`default_nettype wire

// ==== src/ex_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mem (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clear_master,
    input  logic                 clear_slave,
    input  logic                 ena_master,
    input  logic                 ena_slave,
    input  cpu_pkg::mem_master_t master_in,
    input  cpu_pkg::mem_slave_t  slave_in,
    output cpu_pkg::mem_master_t master_out,
    output cpu_pkg::mem_slave_t  slave_out
);

    // ****************************************
    // Master lane
    // ****************************************
    // Clear wins over enable so a flush lands even during a stall
    always_ff @(posedge clk) begin
        if (reset || clear_master) begin
            master_out <= '0;
        end else if (ena_master) begin
            master_out <= master_in;
        end
    end

    // ****************************************
    // Slave lane
    // ****************************************
    always_ff @(posedge clk) begin
        if (reset || clear_slave) begin
            slave_out <= '0;  // All write flags drop with the packet
        end else if (ena_slave) begin
            slave_out <= slave_in;
        end
    end

endmodule

`default_nettype wire

// ==== src/exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  cpu_pkg::ex_master_t  ex_master,
    input  cpu_pkg::ex_slave_t   ex_slave,
    input  logic                 mem_stall,
    input  logic                 flush,
    output cpu_pkg::mem_master_t m_master,
    output cpu_pkg::mem_slave_t  m_slave
);

    cpu_pkg::mem_master_t e_master;
    cpu_pkg::mem_slave_t  e_slave;
    logic                 master_exc;
    logic                 clear_master;
    logic                 clear_slave;
    logic                 ena_master;
    logic                 ena_slave;

    // ****************************************
    // Execute
    // ****************************************
    master_alu u_master_alu (
        .in         (ex_master),
        .out        (e_master),
        .master_exc (master_exc)
    );

    slave_alu u_slave_alu (
        .in  (ex_slave),
        .out (e_slave)
    );

    // ****************************************
    // Control and pipeline register
    // ****************************************
    pipe_ctrl u_pipe_ctrl (
        .mem_stall    (mem_stall),
        .flush        (flush),
        .master_exc   (master_exc),
        .clear_master (clear_master),
        .clear_slave  (clear_slave),
        .ena_master   (ena_master),
        .ena_slave    (ena_slave)
    );

    ex_mem u_ex_mem (
        .clk          (clk),
        .reset        (reset),
        .clear_master (clear_master),
        .clear_slave  (clear_slave),
        .ena_master   (ena_master),
        .ena_slave    (ena_slave),
        .master_in    (e_master),
        .slave_in     (e_slave),
        .master_out   (m_master),
        .slave_out    (m_slave)
    );

endmodule

`default_nettype wire

// ==== src/master_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module master_alu (
    input  cpu_pkg::ex_master_t  in,
    output cpu_pkg::mem_master_t out,
    output logic                 master_exc
);

    logic [`XLEN-1:0]           res;
    logic                       ovf;
    logic                       is_mult;
    logic signed [2*`XLEN-1:0]  prod_s;
    logic [2*`XLEN-1:0]         prod_u;

    // For loads and stores the sum is the memory address
    assign res = cpu_pkg::alu_word(in.op, in.src_a, in.src_b);
    assign ovf = cpu_pkg::alu_ovf(in.op, in.src_a, in.src_b, res);

    // Both products are built and the opcode picks one
    assign prod_s  = $signed({{`XLEN{in.src_a[`XLEN-1]}}, in.src_a})
                   * $signed({{`XLEN{in.src_b[`XLEN-1]}}, in.src_b});
    assign prod_u  = {{`XLEN{1'b0}}, in.src_a} * {{`XLEN{1'b0}}, in.src_b};
    assign is_mult = (in.op == cpu_pkg::OP_MULT) || (in.op == cpu_pkg::OP_MULTU);

    always_comb begin
        out.op              = in.op;
        out.rt_value        = in.rt_value;
        out.pc              = in.pc;
        out.inst            = in.inst;
        out.reg_waddr       = in.reg_waddr;
        out.rd              = in.rd;
        out.mem_en          = in.mem_en;
        out.memtoreg        = in.memtoreg;
        out.cp0write        = in.cp0write;
        out.is_in_delayslot = in.is_in_delayslot;
        out.alu_res         = res;
        out.hilowrite       = is_mult;
        out.reg_wen         = in.reg_wen & ~ovf;  // No register write on overflow

        // ****************************************
        // HI/LO result
        // ****************************************
        case (in.op)
            cpu_pkg::OP_MULT:  out.alu_out64 = prod_s;
            cpu_pkg::OP_MULTU: out.alu_out64 = prod_u;
            default:           out.alu_out64 = '0;
        endcase

        out.except           = in.except;
        out.except[`EXC_OVF] = in.except[`EXC_OVF] | ovf;
    end

    // Any bit, raised here or upstream, squashes the younger slave
    assign master_exc = |out.except;

endmodule

`default_nettype wire

// ==== src/pipe_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
    input  logic mem_stall,
    input  logic flush,
    input  logic master_exc,
    output logic clear_master,
    output logic clear_slave,
    output logic ena_master,
    output logic ena_slave
);

    // ****************************************
    // Lane squash
    // ****************************************
    // A flush empties both lanes even while memory stalls
    assign clear_master = flush;

    // The slave is younger than a faulting master and must not reach memory.
    // During a stall the faulting master has not advanced yet, so the slave holds
    assign clear_slave = flush | (master_exc & ~mem_stall);

    // ****************************************
    // Back-pressure
    // ****************************************
    assign ena_master = ~mem_stall;
    assign ena_slave  = ~mem_stall;  // Lanes move together

endmodule

`default_nettype wire

// ==== src/slave_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module slave_alu (
    input  cpu_pkg::ex_slave_t  in,
    output cpu_pkg::mem_slave_t out
);

    logic [`XLEN-1:0] res;
    logic             ovf;
    logic             bad_op;

    assign res    = cpu_pkg::alu_word(in.op, in.src_a, in.src_b);
    assign ovf    = cpu_pkg::alu_ovf(in.op, in.src_a, in.src_b, res);
    // The multiplier sits in the master lane only
    assign bad_op = (in.op == cpu_pkg::OP_MULT) || (in.op == cpu_pkg::OP_MULTU);

    always_comb begin
        out.op              = in.op;
        out.pc              = in.pc;
        out.inst            = in.inst;
        out.reg_waddr       = in.reg_waddr;
        out.memtoreg        = in.memtoreg;
        out.cp0write        = in.cp0write;
        out.is_in_delayslot = in.is_in_delayslot;
        out.alu_res         = bad_op ? '0 : res;
        out.reg_wen         = in.reg_wen & ~ovf & ~bad_op;

        out.except           = in.except;
        out.except[`EXC_OVF] = in.except[`EXC_OVF] | ovf;
        out.except[`EXC_RI]  = in.except[`EXC_RI] | bad_op;
    end

endmodule

`default_nettype wire

// ==== test/tb_exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_cfg.svh"

module tb_exec_stage;

    localparam int MAX_CYCLES = 1000;  // Reset, 40 directed and 600 random cycles fit well inside

    logic                 clk = 1'b0;
    logic                 reset;
    cpu_pkg::ex_master_t  ex_master;
    cpu_pkg::ex_slave_t   ex_slave;
    logic                 mem_stall;
    logic                 flush;
    cpu_pkg::mem_master_t m_master;
    cpu_pkg::mem_slave_t  m_slave;

    cpu_pkg::mem_master_t exp_master;
    cpu_pkg::mem_slave_t  exp_slave;
    logic                 model_valid = 1'b0;
    logic [31:0]          rng_state;
    int                   cycles = 0;

    exec_stage u_dut (
        .clk       (clk),
        .reset     (reset),
        .ex_master (ex_master),
        .ex_slave  (ex_slave),
        .mem_stall (mem_stall),
        .flush     (flush),
        .m_master  (m_master),
        .m_slave   (m_slave)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic cpu_pkg::alu_op_t pick_op(input logic [31:0] r);
        logic [31:0] v;
        v = r % 32'd12;
        return cpu_pkg::alu_op_t'(v[3:0]);
    endfunction

    // ****************************************
    // Reference model
    // ****************************************
    function automatic logic [`XLEN-1:0] model_word(input cpu_pkg::alu_op_t op,
                                                    input logic [`XLEN-1:0] a,
                                                    input logic [`XLEN-1:0] b);
        logic [`XLEN-1:0] r;
        r = '0;
        case (op)
            cpu_pkg::OP_ADD, cpu_pkg::OP_ADDU: r = a + b;
            cpu_pkg::OP_SUB: r = a - b;
            cpu_pkg::OP_AND: r = a & b;
            cpu_pkg::OP_OR:  r = a | b;
            cpu_pkg::OP_XOR: r = a ^ b;
            cpu_pkg::OP_SLT: r[0] = $signed(a) < $signed(b);
            cpu_pkg::OP_SLL: r = a << b[4:0];
            cpu_pkg::OP_SRL: r = a >> b[4:0];
            cpu_pkg::OP_LUI: r = {b[15:0], 16'h0000};
            default:         r = '0;  // Multiplies leave the word result empty
        endcase
        return r;
    endfunction

    // Overflow when the sign-extended 33-bit result disagrees in its top two bits
    function automatic logic model_ovf(input cpu_pkg::alu_op_t op,
                                       input logic [`XLEN-1:0] a,
                                       input logic [`XLEN-1:0] b);
        logic [`XLEN:0] s;
        case (op)
            cpu_pkg::OP_ADD: s = {a[`XLEN-1], a} + {b[`XLEN-1], b};
            cpu_pkg::OP_SUB: s = {a[`XLEN-1], a} - {b[`XLEN-1], b};
            default:         s = '0;
        endcase
        return s[`XLEN] != s[`XLEN-1];
    endfunction

    function automatic logic [2*`XLEN-1:0] model_product(input cpu_pkg::alu_op_t op,
                                                         input logic [`XLEN-1:0] a,
                                                         input logic [`XLEN-1:0] b);
        logic [2*`XLEN-1:0] ea;
        logic [2*`XLEN-1:0] eb;
        ea = '0;
        eb = '0;
        if (op == cpu_pkg::OP_MULT) begin
            ea = {{`XLEN{a[`XLEN-1]}}, a};
            eb = {{`XLEN{b[`XLEN-1]}}, b};
        end else if (op == cpu_pkg::OP_MULTU) begin
            ea = {{`XLEN{1'b0}}, a};
            eb = {{`XLEN{1'b0}}, b};
        end
        return ea * eb;  // Low 64 bits are exact for both signednesses
    endfunction

    function automatic cpu_pkg::mem_master_t model_master(input cpu_pkg::ex_master_t p);
        cpu_pkg::mem_master_t m;
        logic                 ovf;
        ovf = model_ovf(p.op, p.src_a, p.src_b);
        m.op = p.op;
        m.rt_value = p.rt_value;
        m.pc = p.pc;
        m.inst = p.inst;
        m.reg_waddr = p.reg_waddr;
        m.rd = p.rd;
        m.reg_wen = p.reg_wen && !ovf;
        m.mem_en = p.mem_en;
        m.memtoreg = p.memtoreg;
        m.cp0write = p.cp0write;
        m.is_in_delayslot = p.is_in_delayslot;
        m.except = p.except;
        if (ovf) m.except[`EXC_OVF] = 1'b1;
        m.alu_res = model_word(p.op, p.src_a, p.src_b);
        m.alu_out64 = model_product(p.op, p.src_a, p.src_b);
        m.hilowrite = (p.op == cpu_pkg::OP_MULT) || (p.op == cpu_pkg::OP_MULTU);
        return m;
    endfunction

    function automatic cpu_pkg::mem_slave_t model_slave(input cpu_pkg::ex_slave_t p);
        cpu_pkg::mem_slave_t s;
        logic                ovf;
        logic                bad;
        ovf = model_ovf(p.op, p.src_a, p.src_b);
        bad = (p.op == cpu_pkg::OP_MULT) || (p.op == cpu_pkg::OP_MULTU);
        s.op = p.op;
        s.pc = p.pc;
        s.inst = p.inst;
        s.reg_waddr = p.reg_waddr;
        s.reg_wen = p.reg_wen && !ovf && !bad;
        s.memtoreg = p.memtoreg;
        s.cp0write = p.cp0write;
        s.is_in_delayslot = p.is_in_delayslot;
        s.except = p.except;
        if (ovf) s.except[`EXC_OVF] = 1'b1;
        if (bad) s.except[`EXC_RI] = 1'b1;
        s.alu_res = model_word(p.op, p.src_a, p.src_b);
        return s;
    endfunction

    // Expected packets advance on the same edge as the DUT register
    always @(posedge clk) begin : model_step
        cpu_pkg::mem_master_t next_master;
        next_master = model_master(ex_master);
        model_valid <= 1'b1;
        if (reset || flush) begin
            exp_master <= '0;
        end else if (!mem_stall) begin
            exp_master <= next_master;
        end
        if (reset || flush || ((|next_master.except) && !mem_stall)) begin
            exp_slave <= '0;  // Younger slave dies behind a faulting master
        end else if (!mem_stall) begin
            exp_slave <= model_slave(ex_slave);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Finished with errors");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // ****************************************
    // Checks
    // ****************************************
    task automatic report_mismatch(input string name, input logic [255:0] got,
                                   input logic [255:0] expected);
        $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
        $display("Finished with errors");
        $fatal(1, "Output check failed");
    endtask

    a_m_res: assert property (@(posedge clk) disable iff (!model_valid)
        m_master.alu_res == exp_master.alu_res)
        else report_mismatch("m_master.alu_res", 256'($sampled(m_master.alu_res)),
                             256'($sampled(exp_master.alu_res)));
    a_m_prod: assert property (@(posedge clk) disable iff (!model_valid)
        m_master.alu_out64 == exp_master.alu_out64)
        else report_mismatch("m_master.alu_out64", 256'($sampled(m_master.alu_out64)),
                             256'($sampled(exp_master.alu_out64)));
    a_m_hilo: assert property (@(posedge clk) disable iff (!model_valid)
        m_master.hilowrite == exp_master.hilowrite)
        else report_mismatch("m_master.hilowrite", 256'($sampled(m_master.hilowrite)),
                             256'($sampled(exp_master.hilowrite)));
    a_m_exc: assert property (@(posedge clk) disable iff (!model_valid)
        m_master.except == exp_master.except)
        else report_mismatch("m_master.except", 256'($sampled(m_master.except)),
                             256'($sampled(exp_master.except)));
    a_m_wen: assert property (@(posedge clk) disable iff (!model_valid)
        m_master.reg_wen == exp_master.reg_wen)
        else report_mismatch("m_master.reg_wen", 256'($sampled(m_master.reg_wen)),
                             256'($sampled(exp_master.reg_wen)));
    a_m_all: assert property (@(posedge clk) disable iff (!model_valid)
        m_master == exp_master)
        else report_mismatch("m_master", 256'($sampled(m_master)),
                             256'($sampled(exp_master)));
    a_s_res: assert property (@(posedge clk) disable iff (!model_valid)
        m_slave.alu_res == exp_slave.alu_res)
        else report_mismatch("m_slave.alu_res", 256'($sampled(m_slave.alu_res)),
                             256'($sampled(exp_slave.alu_res)));
    a_s_exc: assert property (@(posedge clk) disable iff (!model_valid)
        m_slave.except == exp_slave.except)
        else report_mismatch("m_slave.except", 256'($sampled(m_slave.except)),
                             256'($sampled(exp_slave.except)));
    a_s_wen: assert property (@(posedge clk) disable iff (!model_valid)
        m_slave.reg_wen == exp_slave.reg_wen)
        else report_mismatch("m_slave.reg_wen", 256'($sampled(m_slave.reg_wen)),
                             256'($sampled(exp_slave.reg_wen)));
    a_s_all: assert property (@(posedge clk) disable iff (!model_valid)
        m_slave == exp_slave)
        else report_mismatch("m_slave", 256'($sampled(m_slave)),
                             256'($sampled(exp_slave)));

    // ****************************************
    // Stimulus
    // ****************************************
    task automatic near_overflow(output logic [31:0] a, output logic [31:0] b);
        logic [31:0] r;
        r = next_rand();
        a = r[0] ? 32'h8000_0000 + {27'b0, r[8:4]} : 32'h7fff_ffe0 + {27'b0, r[8:4]};
        b = r[1] ? {27'b0, r[16:12]} + 32'd1 : 32'hffff_ffff - {27'b0, r[16:12]};
    endtask

    task automatic fill_packets();
        logic [191:0] bits;
        logic [31:0]  r;
        bits = {next_rand(), next_rand(), next_rand(), next_rand(), next_rand(), next_rand()};
        ex_master = bits[$bits(cpu_pkg::ex_master_t)-1:0];
        bits = {next_rand(), next_rand(), next_rand(), next_rand(), next_rand(), next_rand()};
        ex_slave = bits[$bits(cpu_pkg::ex_slave_t)-1:0];
        r = next_rand();
        ex_master.op = pick_op(r);
        ex_slave.op = pick_op(r >> 8);
        ex_master.except = (r[19:16] == 4'h0) ? (r[31:24] & 8'hfc) : 8'h00;
        ex_slave.except = (r[23:20] == 4'h0) ? (r[31:24] & 8'hfc) : 8'h00;
        if (r[26:24] == 3'd0) near_overflow(ex_master.src_a, ex_master.src_b);
        if (r[29:27] == 3'd0) near_overflow(ex_slave.src_a, ex_slave.src_b);
    endtask

    task automatic directed(input cpu_pkg::alu_op_t mop, input logic [31:0] ma,
                            input logic [31:0] mb, input cpu_pkg::alu_op_t sop,
                            input logic [31:0] sa, input logic [31:0] sb,
                            input logic [7:0] mexc, input logic stall, input logic fl);
        @(negedge clk);
        fill_packets();
        ex_master.op = mop;
        ex_master.src_a = ma;
        ex_master.src_b = mb;
        ex_master.except = mexc;
        ex_master.reg_wen = 1'b1;
        ex_slave.op = sop;
        ex_slave.src_a = sa;
        ex_slave.src_b = sb;
        ex_slave.except = '0;
        ex_slave.reg_wen = 1'b1;
        mem_stall = stall;
        flush = fl;
    endtask

    task automatic random_cycle();
        logic [31:0] r;
        @(negedge clk);
        fill_packets();
        r = next_rand();
        mem_stall = (r[7:0] < 8'd51);  // About one cycle in five
        flush = (r[15:8] < 8'd13);  // About one in twenty
    endtask

    initial begin
        rng_state = 32'h44fac1a0;
        reset = 1'b1;
        ex_master = '0;
        ex_slave = '0;
        mem_stall = 1'b0;
        flush = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Overflow, products and slave-lane multiplies
        directed(cpu_pkg::OP_ADD, 32'h7fff_ffff, 32'h1, cpu_pkg::OP_ADDU,
                 32'h1234_5678, 32'h1111_1111, 8'h00, 1'b0, 1'b0);
        directed(cpu_pkg::OP_SUB, 32'h8000_0000, 32'h1, cpu_pkg::OP_SUB,
                 32'h7fff_ffff, 32'hffff_ffff, 8'h00, 1'b0, 1'b0);
        directed(cpu_pkg::OP_MULT, 32'hffff_fffe, 32'h3, cpu_pkg::OP_ADD,
                 32'h7fff_ffff, 32'h7, 8'h00, 1'b0, 1'b0);
        directed(cpu_pkg::OP_MULTU, 32'hffff_ffff, 32'hffff_ffff, cpu_pkg::OP_MULT,
                 32'h2, 32'h3, 8'h00, 1'b0, 1'b0);
        // Stall holds, then a flush lands inside the stall
        directed(cpu_pkg::OP_MULT, 32'h8000_0000, 32'h8000_0000, cpu_pkg::OP_MULTU,
                 32'h1, 32'h1, 8'h00, 1'b1, 1'b0);
        directed(cpu_pkg::OP_AND, 32'hf0f0_f0f0, 32'hff00_ff00, cpu_pkg::OP_OR,
                 32'h1, 32'h2, 8'h00, 1'b1, 1'b0);
        directed(cpu_pkg::OP_OR, 32'h1, 32'h2, cpu_pkg::OP_XOR,
                 32'h3, 32'h5, 8'h00, 1'b1, 1'b1);
        directed(cpu_pkg::OP_XOR, 32'haaaa_5555, 32'h0f0f_0f0f, cpu_pkg::OP_SLT,
                 32'hffff_ffff, 32'h1, 8'h00, 1'b0, 1'b0);
        // Faulting master squashes the slave unless stalled
        directed(cpu_pkg::OP_ADDU, 32'h10, 32'h20, cpu_pkg::OP_OR,
                 32'h30, 32'h40, 8'h20, 1'b0, 1'b0);
        directed(cpu_pkg::OP_ADD, 32'h7fff_ffff, 32'h7fff_ffff, cpu_pkg::OP_ADD,
                 32'h1, 32'h2, 8'h00, 1'b1, 1'b0);
        directed(cpu_pkg::OP_ADD, 32'h1, 32'h2, cpu_pkg::OP_SUB,
                 32'h9, 32'h3, 8'h00, 1'b0, 1'b1);
        for (int k = 0; k < 12; k++) begin
            directed(cpu_pkg::alu_op_t'(4'(k)), next_rand(), next_rand(),
                     cpu_pkg::alu_op_t'(4'(11 - k)), next_rand(), next_rand(),
                     8'h00, 1'b0, 1'b0);
        end
        repeat (17) begin
            directed(pick_op(next_rand()), next_rand(), next_rand(), pick_op(next_rand()),
                     next_rand(), next_rand(), 8'h00, 1'b0, 1'b0);
        end

        repeat (600) random_cycle();

        @(negedge clk);
        mem_stall = 1'b0;
        flush = 1'b0;
        repeat (2) @(negedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire
